// ==== design/led_strip_pkg.sv ====
`default_nettype none

package led_strip_pkg;

    // Every word on the strip is 32 bits long
    localparam int WORD_BITS = 32;

    // Leading ones of an LED frame
    localparam logic [2:0] LED_FRAME_HDR = 3'b111;

    typedef logic [WORD_BITS - 1:0]         led_word_t;
    typedef logic [$clog2(WORD_BITS) - 1:0] bit_count_t;   // Bit position within a word
    typedef logic [4:0]                     brightness_t;  // Global brightness field
    typedef logic [7:0]                     color_t;       // One color channel

    // One LED setting, laid out in the order it goes on the wire
    typedef struct packed {
        brightness_t brightness;
        color_t      blue;
        color_t      green;
        color_t      red;
    } led_pixel_t;

    // Which word the shifter forms next
    typedef enum logic [1:0] {
        START_WORD,
        PIXEL_WORD,
        END_WORD
    } word_kind_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_PIXELS,
        S_END,
        S_ACK
    } frame_state_e;

endpackage

`default_nettype wire

// ==== design/led_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_frame_buffer
    import led_strip_pkg::*;
#(
    parameter int NUM_LEDS = 13
)
(
    input  wire                                  clk,
    input  wire                                  i_rst_n,

    input  wire                                  i_load,
    input  led_pixel_t [NUM_LEDS - 1:0]          i_pixels,

    input  wire  [((NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1) - 1:0] i_index,
    output led_pixel_t                           o_pixel
);

    // ------------------------------
    // Frame copy
    // ------------------------------

    // Pixel 0 sits in the lowest slot and goes out first
    led_pixel_t [NUM_LEDS - 1:0] frame_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            frame_q <= '0;          // Dark frame until the first request
        end else if (i_load) begin
            frame_q <= i_pixels;    // Source is free to change its pixels after this
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // The FSM keeps the index in range, it only counts up to NUM_LEDS - 1
    assign o_pixel = frame_q[i_index];

endmodule

`default_nettype wire

// ==== design/spi_bit_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_bit_timer
    import led_strip_pkg::*;
#(
    parameter int CLK_DIV = 2
)
(
    input  wire  clk,
    input  wire  i_rst_n,

    input  wire  i_run,         // High while a frame is on the wire
    input  wire  i_start,       // Restart at bit 0, low phase

    output logic o_sk_clk,
    output logic o_shift_tick,  // End of a high phase, data may change
    output logic o_word_done    // One cycle after the high phase of the last bit
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    localparam logic [DIV_W - 1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
    localparam bit_count_t         BIT_LAST = bit_count_t'(WORD_BITS - 1);

    logic [DIV_W - 1:0] div_cnt;
    bit_count_t         bit_cnt;
    logic               sk_clk_q;
    logic               word_done_q;

    logic               phase_end;
    logic               fall;

    assign phase_end = (div_cnt == DIV_LAST);
    assign fall      = phase_end && sk_clk_q;   // High phase ends on this clock

    // ------------------------------
    // Divider and bit counter
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_start || !i_run) begin
            div_cnt     <= '0;
            bit_cnt     <= '0;
            sk_clk_q    <= 1'b0;
            word_done_q <= 1'b0;
        end else if (word_done_q) begin
            // Pause one cycle so the FSM can pick the next word
            word_done_q <= 1'b0;
        end else begin
            if (phase_end) begin
                div_cnt  <= '0;
                sk_clk_q <= !sk_clk_q;
            end else begin
                div_cnt  <= div_cnt + 1'b1;
            end

            if (fall) begin
                bit_cnt <= bit_cnt + 1'b1;  // Wraps to 0 after the last bit
                if (bit_cnt == BIT_LAST)
                    word_done_q <= 1'b1;
            end
        end
    end

    assign o_sk_clk     = sk_clk_q;
    assign o_word_done  = word_done_q;

    // No shift after the last bit, the next word is loaded instead
    assign o_shift_tick = fall && (bit_cnt != BIT_LAST);

endmodule

`default_nettype wire

// ==== design/led_word_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_word_shifter
    import led_strip_pkg::*;
(
    input  wire        clk,
    input  wire        i_rst_n,

    input  wire        i_start,     // Load a new word
    input  word_kind_e i_kind,
    input  led_pixel_t i_pixel,

    input  wire        i_shift,     // Advance to the next bit
    output logic       o_data
);

    led_word_t shift_q;
    led_word_t pixel_word;

    // Header, brightness, blue, green, red
    assign pixel_word = {LED_FRAME_HDR, i_pixel};

    // ------------------------------
    // Word load and shift
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            shift_q <= '0;                          // Data line low out of reset
        end else if (i_start) begin
            unique case (i_kind)
                START_WORD: shift_q <= '0;
                END_WORD:   shift_q <= '1;
                default:    shift_q <= pixel_word;
            endcase
        end else if (i_shift) begin
            shift_q <= {shift_q[WORD_BITS - 2:0], 1'b0};
        end
    end

    // MSB first
    assign o_data = shift_q[WORD_BITS - 1];

endmodule

`default_nettype wire

// ==== design/led_frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_frame_fsm
    import led_strip_pkg::*;
#(
    parameter int NUM_LEDS = 13
)
(
    input  wire        clk,
    input  wire        i_rst_n,

    input  wire        i_req,
    input  wire        i_word_done,

    output logic       o_ack,
    output logic       o_load,      // Copy the frame into the buffer
    output logic       o_run,       // Strip clock enable
    output logic       o_start,     // First cycle of a new word
    output word_kind_e o_kind,
    output logic [((NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1) - 1:0] o_index
);

    localparam int IDX_W = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

    localparam logic [IDX_W - 1:0] LAST_IDX = IDX_W'(NUM_LEDS - 1);

    frame_state_e       state_q;
    frame_state_e       state_d;

    logic [IDX_W - 1:0] led_idx;    // Next pixel to load
    logic               last_pix;   // Final pixel is on the wire
    logic               pixel_start;

    // ------------------------------
    // Next state and word requests
    // ------------------------------

    always_comb begin
        state_d = state_q;
        o_load  = 1'b0;
        o_start = 1'b0;
        o_kind  = START_WORD;

        unique case (state_q)
            S_IDLE: begin
                if (i_req) begin
                    o_load  = 1'b1;
                    o_start = 1'b1;                 // 32 zeros go out first
                    state_d = S_START;
                end
            end
            S_START: begin
                if (i_word_done) begin
                    o_start = 1'b1;
                    o_kind  = PIXEL_WORD;
                    state_d = S_PIXELS;
                end
            end
            S_PIXELS: begin
                if (i_word_done) begin
                    o_start = 1'b1;
                    if (last_pix) begin
                        o_kind  = END_WORD;
                        state_d = S_END;
                    end else begin
                        o_kind  = PIXEL_WORD;
                    end
                end
            end
            S_END:   if (i_word_done) state_d = S_ACK;
            S_ACK:   if (!i_req)      state_d = S_IDLE;  // Wait for the source to drop req
            default: state_d = S_IDLE;
        endcase
    end

    assign pixel_start = o_start && (o_kind == PIXEL_WORD);

    // ------------------------------
    // State and LED index
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q  <= S_IDLE;
            led_idx  <= '0;
            last_pix <= 1'b0;
        end else begin
            state_q <= state_d;

            if (o_load) begin
                led_idx  <= '0;
                last_pix <= 1'b0;
            end else if (pixel_start) begin
                if (led_idx == LAST_IDX)
                    last_pix <= 1'b1;
                else
                    led_idx  <= led_idx + 1'b1;
            end
        end
    end

    assign o_run   = (state_q == S_START) || (state_q == S_PIXELS) || (state_q == S_END);
    assign o_ack   = (state_q == S_ACK);
    assign o_index = led_idx;

endmodule

`default_nettype wire

// ==== design/led_strip_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_strip_ctrl
    import led_strip_pkg::*;
#(
    parameter int NUM_LEDS = 13,
    parameter int CLK_DIV  = 2      // System clocks per strip clock half period
)
(
    input  wire                         clk,
    input  wire                         i_rst_n,

    input  wire                         i_req,
    input  led_pixel_t [NUM_LEDS - 1:0] i_pixels,   // Pixel 0 is sent first
    output logic                        o_ack,

    output logic                        o_sk_clk,
    output logic                        o_sk_data
);

    localparam int IDX_W = (NUM_LEDS > 1) ? $clog2(NUM_LEDS) : 1;

    logic               load_buf;
    logic               start_word;
    word_kind_e         word_kind;
    logic               run;
    logic               shift_tick;
    logic               word_done;
    logic [IDX_W - 1:0] led_index;
    led_pixel_t         cur_pixel;

    // ------------------------------
    // Sequencing
    // ------------------------------

    led_frame_fsm #(
        .NUM_LEDS    ( NUM_LEDS   )
    ) led_frame_fsm_i (
        .clk         ( clk        ),
        .i_rst_n     ( i_rst_n    ),
        .i_req       ( i_req      ),
        .i_word_done ( word_done  ),
        .o_ack       ( o_ack      ),
        .o_load      ( load_buf   ),
        .o_run       ( run        ),
        .o_start     ( start_word ),
        .o_kind      ( word_kind  ),
        .o_index     ( led_index  )
    );

    led_frame_buffer #(
        .NUM_LEDS    ( NUM_LEDS   )
    ) led_frame_buffer_i (
        .clk         ( clk        ),
        .i_rst_n     ( i_rst_n    ),
        .i_load      ( load_buf   ),
        .i_pixels    ( i_pixels   ),
        .i_index     ( led_index  ),
        .o_pixel     ( cur_pixel  )
    );

    // ------------------------------
    // Serial side
    // ------------------------------

    spi_bit_timer #(
        .CLK_DIV      ( CLK_DIV    )
    ) spi_bit_timer_i (
        .clk          ( clk        ),
        .i_rst_n      ( i_rst_n    ),
        .i_run        ( run        ),
        .i_start      ( start_word ),
        .o_sk_clk     ( o_sk_clk   ),
        .o_shift_tick ( shift_tick ),
        .o_word_done  ( word_done  )
    );

    led_word_shifter led_word_shifter_i (
        .clk     ( clk        ),
        .i_rst_n ( i_rst_n    ),
        .i_start ( start_word ),
        .i_kind  ( word_kind  ),
        .i_pixel ( cur_pixel  ),
        .i_shift ( shift_tick ),
        .o_data  ( o_sk_data  )
    );

endmodule

`default_nettype wire

// ==== tb/led_strip_ctrl_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_strip_ctrl_sva (
    input wire clk,
    input wire i_rst_n,
    input wire i_req,
    input wire o_ack,
    input wire o_sk_clk,
    input wire o_sk_data
);

    int unsigned fail_count = 0;    // Assertion failures so far

    // ------------------------------
    // Handshake
    // ------------------------------

    ack_needs_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(o_ack) |-> i_req)
        else begin fail_count++; $error("o_ack rose without i_req"); end

    ack_held_with_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        $fell(o_ack) |-> !$past(i_req))
        else begin fail_count++; $error("o_ack fell while i_req was high"); end

    // ------------------------------
    // Strip clock
    // ------------------------------

    data_stable_high: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_sk_clk |-> $stable(o_sk_data))
        else begin fail_count++; $error("o_sk_data changed while o_sk_clk was high"); end

    // No strip activity while the frame is acknowledged
    quiet_during_ack: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_ack |-> !o_sk_clk)
        else begin fail_count++; $error("o_sk_clk high during o_ack"); end

endmodule

bind led_strip_ctrl led_strip_ctrl_sva led_strip_ctrl_sva_i (
    .clk       ( clk       ),
    .i_rst_n   ( i_rst_n   ),
    .i_req     ( i_req     ),
    .o_ack     ( o_ack     ),
    .o_sk_clk  ( o_sk_clk  ),
    .o_sk_data ( o_sk_data )
);

`default_nettype wire

// ==== tb/tb_led_strip_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_led_strip_ctrl
    import led_strip_pkg::*;
();

    localparam int NUM_LEDS   = 13;
    localparam int CLK_DIV    = 2;
    localparam int FRAME_BITS = (NUM_LEDS + 2) * WORD_BITS;
    localparam int ACK_LIMIT  = 4 * FRAME_BITS * CLK_DIV;   // Cycles, about twice a frame

    logic                        clk;
    logic                        i_rst_n;
    logic                        i_req;
    led_pixel_t [NUM_LEDS - 1:0] i_pixels;
    logic                        o_ack;
    logic                        o_sk_clk;
    logic                        o_sk_data;

    led_pixel_t [NUM_LEDS - 1:0] frame;
    logic                        exp_bits[$];   // Bits still due on the strip
    logic                        exp_bit;
    logic                        sk_clk_prev;
    int                          sk_edges;
    int                          bit_no;
    int                          frame_no;
    int                          checks;
    int                          errors;
    int                          seed;
    int                          idx;

    led_strip_ctrl #(
        .NUM_LEDS  ( NUM_LEDS  ),
        .CLK_DIV   ( CLK_DIV   )
    ) led_strip_ctrl_i (
        .clk       ( clk       ),
        .i_rst_n   ( i_rst_n   ),
        .i_req     ( i_req     ),
        .i_pixels  ( i_pixels  ),
        .o_ack     ( o_ack     ),
        .o_sk_clk  ( o_sk_clk  ),
        .o_sk_data ( o_sk_data )
    );

    initial clk = 1'b0;
    always #50 clk = !clk;      // 100 ns period

    // ------------------------------
    // Reference model
    // ------------------------------

    // Bit FRAME_BITS - 1 goes out first
    function automatic logic [FRAME_BITS - 1:0] expand_frame(input led_pixel_t [NUM_LEDS - 1:0] pix);
        logic [FRAME_BITS - 1:0] stream;
        int                      n;
        stream = '0;                                // Start frame of zeros
        for (n = 0; n < NUM_LEDS; n++)
            stream[FRAME_BITS - 1 - WORD_BITS * (n + 1) -: WORD_BITS] =
                {3'b111, pix[n].brightness, pix[n].blue, pix[n].green, pix[n].red};
        stream[WORD_BITS - 1:0] = '1;               // End frame of ones
        return stream;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("ERROR at %0t ns: %s", $time, why);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_ack(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (o_ack !== level) begin
            if (cycles >= limit)
                abort_run($sformatf("o_ack did not reach %0b within %0d cycles", level, limit));
            next_cycle();
            cycles++;
        end
    endtask

    task automatic random_frame(output led_pixel_t [NUM_LEDS - 1:0] pix);
        logic [31:0] r;
        int          n;
        for (n = 0; n < NUM_LEDS; n++) begin
            r      = $random(seed);
            pix[n] = r[28:0];
        end
    endtask

    // ------------------------------
    // Request driver
    // ------------------------------

    task automatic send_frame(input led_pixel_t [NUM_LEDS - 1:0] pix, input bit scramble);
        logic [FRAME_BITS - 1:0] stream;
        int                      edges_at_req;
        int                      cycles;
        int                      b;
        stream = expand_frame(pix);
        for (b = FRAME_BITS - 1; b >= 0; b--)
            exp_bits.push_back(stream[b]);
        bit_no       = 0;
        edges_at_req = sk_edges;
        i_pixels     = pix;
        i_req        = 1'b1;
        next_cycle();                   // Accepted on this edge
        if (scramble)
            i_pixels = ~pix;            // Must not reach the strip
        wait_ack(1'b1, ACK_LIMIT, cycles);
        check_equal(sk_edges - edges_at_req, FRAME_BITS, "strip clock edges before ack");
        check_equal(exp_bits.size(), 0, "bits left unsent at ack");
        repeat (6) begin
            next_cycle();
            check_equal(o_ack, 1'b1, "ack held while req high");
        end
        i_req = 1'b0;
        wait_ack(1'b0, 4, cycles);
        check_equal(cycles, 1, "cycles from req low to ack low");
        check_equal(sk_edges - edges_at_req, FRAME_BITS, "strip clock edges after ack");
        frame_no++;
    endtask

    // Stream decoder, compares every bit at the strip clock rising edge
    always @(negedge clk) begin
        if (o_sk_clk && !sk_clk_prev) begin
            sk_edges++;
            if (exp_bits.size() == 0) begin
                errors++;
                $display("ERROR at %0t ns: strip clock rose with no frame in progress", $time);
            end else begin
                exp_bit = exp_bits.pop_front();
                check_equal(o_sk_data, exp_bit, $sformatf("frame %0d bit %0d", frame_no, bit_no));
                bit_no++;
            end
        end
        sk_clk_prev = o_sk_clk;
    end

    initial begin
        seed        = 6;
        checks      = 0;
        errors      = 0;
        frame_no    = 0;
        bit_no      = 0;
        sk_edges    = 0;
        sk_clk_prev = 1'b0;
        i_rst_n     = 1'b0;
        i_req       = 1'b0;
        i_pixels    = '0;
        repeat (4) @(posedge clk);
        #1 i_rst_n = 1'b1;

        repeat (20) begin               // Strip quiet before any request
            next_cycle();
            check_equal({o_ack, o_sk_clk, o_sk_data}, 3'b000, "outputs idle after reset");
        end

        for (idx = 0; idx < NUM_LEDS; idx++)
            frame[idx] = '{brightness: 5'(3 * idx + 1), blue: 8'(17 * idx),
                           green: 8'h5a ^ 8'(idx), red: 8'(255 - 9 * idx)};
        send_frame(frame, 1'b0);

        random_frame(frame);
        send_frame(frame, 1'b1);

        repeat (8) begin
            random_frame(frame);
            send_frame(frame, 1'b0);
        end

        errors += led_strip_ctrl_i.led_strip_ctrl_sva_i.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/led_strip_pkg.sv
design/led_frame_buffer.sv
design/spi_bit_timer.sv
design/led_word_shifter.sv
design/led_frame_fsm.sv
design/led_strip_ctrl.sv
tb/led_strip_ctrl_sva.sv
tb/tb_led_strip_ctrl.sv

// ==== Makefile ====
VERILATOR   := verilator
FILE_LIST   := files.f
TOP         := tb_led_strip_ctrl
RTL_TOP     := led_strip_ctrl
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_MSG    := Simulation failed
LINT_FLAGS  := --lint-only -Wall --top-module $(RTL_TOP)
BUILD_FLAGS := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ_DIR)
SIM_ARGS    := +verilator+error+limit+1000
RTL_FILES   := $(filter design/%,$(shell cat $(FILE_LIST)))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES)

sim:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
